//--- rtl/isa_pkg.sv
package isa_pkg;

	// instruction field positions
	localparam int op_lsb = 26;
	localparam int rs_lsb = 21;
	localparam int rt_lsb = 16;
	localparam int rd_lsb = 11;
	localparam int shamt_lsb = 6;
	localparam int reg_bits = 5;

	// major opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'h00,
		OP_REGIMM = 6'h01,
		OP_J      = 6'h02,
		OP_JAL    = 6'h03,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_ADDIU  = 6'h09,
		OP_SLTI   = 6'h0a,
		OP_SLTIU  = 6'h0b,
		OP_ANDI   = 6'h0c,
		OP_ORI    = 6'h0d,
		OP_XORI   = 6'h0e,
		OP_LUI    = 6'h0f,
		OP_LW     = 6'h23,
		OP_SW     = 6'h2b
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// REGIMM selector in the rt field
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'h00,
		RT_BGEZ   = 5'h01,
		RT_BLTZAL = 5'h10,
		RT_BGEZAL = 5'h11
	} regimm_e;

endpackage

//--- rtl/core_pkg.sv
package core_pkg;

	localparam int mem_words = 1024;
	localparam int addr_bits = 10;
	localparam logic [31:0] reset_pc = 32'h0000_0000;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP,
		BR_JUMP_REG
	} branch_e;

	typedef struct packed {
		alu_op_e alu_op;
		branch_e branch;
		logic regwrite;
		logic regdst;
		logic link;
		logic is_imm;
		logic sign_ex;
		logic shift_imm;
		logic mem_read;
		logic mem_write;
		logic ri;
	} ctrl_t;

	typedef struct packed {
		logic write;
		logic [addr_bits-1:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic we;
		logic [4:0] rd;
		logic [31:0] value;
	} trace_t;

endpackage

//--- rtl/main_decoder.sv
`timescale 1ns/1ns

module main_decoder (
	input logic [31:0] instr,
	output core_pkg::ctrl_t ctrl
);

	isa_pkg::opcode_e op;
	isa_pkg::funct_e funct;
	isa_pkg::regimm_e rt_sel;

	assign op = isa_pkg::opcode_e'(instr[isa_pkg::op_lsb +: 6]);
	assign funct = isa_pkg::funct_e'(instr[5:0]);
	assign rt_sel = isa_pkg::regimm_e'(instr[isa_pkg::rt_lsb +: isa_pkg::reg_bits]);

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = core_pkg::ALU_ADD;
		ctrl.branch = core_pkg::BR_NONE;
		case (op)
			isa_pkg::OP_R_TYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				case (funct)
					isa_pkg::FN_ADDU: ctrl.alu_op = core_pkg::ALU_ADD;
					isa_pkg::FN_SUBU: ctrl.alu_op = core_pkg::ALU_SUB;
					isa_pkg::FN_AND: ctrl.alu_op = core_pkg::ALU_AND;
					isa_pkg::FN_OR: ctrl.alu_op = core_pkg::ALU_OR;
					isa_pkg::FN_XOR: ctrl.alu_op = core_pkg::ALU_XOR;
					isa_pkg::FN_NOR: ctrl.alu_op = core_pkg::ALU_NOR;
					isa_pkg::FN_SLT: ctrl.alu_op = core_pkg::ALU_SLT;
					isa_pkg::FN_SLTU: ctrl.alu_op = core_pkg::ALU_SLTU;
					isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
						ctrl.shift_imm = 1'b1;
						if (funct == isa_pkg::FN_SLL)
							ctrl.alu_op = core_pkg::ALU_SLL;
						else if (funct == isa_pkg::FN_SRL)
							ctrl.alu_op = core_pkg::ALU_SRL;
						else
							ctrl.alu_op = core_pkg::ALU_SRA;
					end
					isa_pkg::FN_JR: begin
						ctrl.regwrite = 1'b0;
						ctrl.regdst = 1'b0;
						ctrl.branch = core_pkg::BR_JUMP_REG;
					end
					default: begin
						ctrl.regwrite = 1'b0;
						ctrl.regdst = 1'b0;
						ctrl.ri = 1'b1;
					end
				endcase
			end
			isa_pkg::OP_REGIMM: begin
				case (rt_sel)
					// sign-test branches are not part of this core
					isa_pkg::RT_BLTZ, isa_pkg::RT_BGEZ,
					isa_pkg::RT_BLTZAL, isa_pkg::RT_BGEZAL: ctrl.ri = 1'b1;
					default: ctrl.ri = 1'b1;
				endcase
			end
			isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU: begin
				ctrl.regwrite = 1'b1;
				ctrl.is_imm = 1'b1;
				ctrl.sign_ex = 1'b1;
				if (op == isa_pkg::OP_SLTI)
					ctrl.alu_op = core_pkg::ALU_SLT;
				else if (op == isa_pkg::OP_SLTIU)
					ctrl.alu_op = core_pkg::ALU_SLTU;
			end
			isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI, isa_pkg::OP_LUI: begin
				// logic immediates are zero extended
				ctrl.regwrite = 1'b1;
				ctrl.is_imm = 1'b1;
				if (op == isa_pkg::OP_ANDI)
					ctrl.alu_op = core_pkg::ALU_AND;
				else if (op == isa_pkg::OP_ORI)
					ctrl.alu_op = core_pkg::ALU_OR;
				else if (op == isa_pkg::OP_XORI)
					ctrl.alu_op = core_pkg::ALU_XOR;
				else
					ctrl.alu_op = core_pkg::ALU_LUI;
			end
			isa_pkg::OP_LW, isa_pkg::OP_SW: begin
				ctrl.is_imm = 1'b1;
				ctrl.sign_ex = 1'b1;
				ctrl.mem_read = (op == isa_pkg::OP_LW);
				ctrl.mem_write = (op == isa_pkg::OP_SW);
				ctrl.regwrite = (op == isa_pkg::OP_LW);
			end
			// branch offsets are signed
			isa_pkg::OP_BEQ: begin
				ctrl.branch = core_pkg::BR_EQ;
				ctrl.sign_ex = 1'b1;
			end
			isa_pkg::OP_BNE: begin
				ctrl.branch = core_pkg::BR_NE;
				ctrl.sign_ex = 1'b1;
			end
			isa_pkg::OP_J: ctrl.branch = core_pkg::BR_JUMP;
			isa_pkg::OP_JAL: begin
				ctrl.branch = core_pkg::BR_JUMP;
				ctrl.link = 1'b1;
				ctrl.regwrite = 1'b1;
				ctrl.alu_op = core_pkg::ALU_PASS_B;
			end
			default: ctrl.ri = 1'b1;
		endcase
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
	input core_pkg::alu_op_e op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [4:0] shamt,
	output logic [31:0] result
);

	always_comb begin
		case (op)
			core_pkg::ALU_ADD: result = a + b;
			core_pkg::ALU_SUB: result = a - b;
			core_pkg::ALU_AND: result = a & b;
			core_pkg::ALU_OR: result = a | b;
			core_pkg::ALU_XOR: result = a ^ b;
			core_pkg::ALU_NOR: result = ~(a | b);
			core_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
			core_pkg::ALU_SLTU: result = {31'b0, a < b};
			// shifts act on the rt operand
			core_pkg::ALU_SLL: result = b << shamt;
			core_pkg::ALU_SRL: result = b >> shamt;
			core_pkg::ALU_SRA: result = $signed(b) >>> shamt;
			core_pkg::ALU_LUI: result = {b[15:0], 16'b0};
			core_pkg::ALU_PASS_B: result = b;
			default: result = 32'b0;
		endcase
	end

endmodule

//--- rtl/exec_core.sv
`timescale 1ns/1ns

module exec_core (
	input logic clk,
	input logic rst_n,
	input logic run,
	output logic fetch_start,
	output logic [31:0] fetch_pc,
	input logic fetch_done,
	input logic [31:0] fetch_instr,
	output logic ls_start,
	output core_pkg::mem_req_t ls_req,
	input logic ls_done,
	input logic [31:0] ls_rdata,
	output logic retire,
	output core_pkg::trace_t trace,
	output logic ri,
	output logic [31:0] ri_pc,
	output logic halted
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_EXEC,
		ST_MEM,
		ST_HALT
	} state_e;

	state_e state;
	logic [31:0] pc;
	logic [31:0] ir;
	logic mem_done;
	logic [31:0] regs [32];
	core_pkg::ctrl_t ctrl;
	logic [4:0] rs_idx, rt_idx, rd_idx, dest;
	logic [31:0] rs_val, rt_val, imm_ext, alu_b, alu_result, wb_data;
	logic [31:0] pc_plus4, br_target, j_target, next_pc;
	logic [4:0] alu_shamt;
	logic is_mem;

	main_decoder u_dec (
		.instr(ir),
		.ctrl(ctrl)
	);

	assign rs_idx = ir[isa_pkg::rs_lsb +: isa_pkg::reg_bits];
	assign rt_idx = ir[isa_pkg::rt_lsb +: isa_pkg::reg_bits];
	assign rd_idx = ir[isa_pkg::rd_lsb +: isa_pkg::reg_bits];
	// register 0 reads as zero
	assign rs_val = (rs_idx == 5'd0) ? 32'b0 : regs[rs_idx];
	assign rt_val = (rt_idx == 5'd0) ? 32'b0 : regs[rt_idx];

	assign imm_ext = ctrl.sign_ex ? {{16{ir[15]}}, ir[15:0]} : {16'b0, ir[15:0]};
	assign pc_plus4 = pc + 32'd4;
	assign alu_b = ctrl.link ? pc_plus4 : (ctrl.is_imm ? imm_ext : rt_val);
	assign alu_shamt = ctrl.shift_imm ? ir[isa_pkg::shamt_lsb +: 5] : rs_val[4:0];

	alu u_alu (
		.op(ctrl.alu_op),
		.a(rs_val),
		.b(alu_b),
		.shamt(alu_shamt),
		.result(alu_result)
	);

	// no delay slot, targets relative to pc+4
	assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign j_target = {pc_plus4[31:28], ir[25:0], 2'b00};

	always_comb begin
		case (ctrl.branch)
			core_pkg::BR_EQ: next_pc = (rs_val == rt_val) ? br_target : pc_plus4;
			core_pkg::BR_NE: next_pc = (rs_val != rt_val) ? br_target : pc_plus4;
			core_pkg::BR_JUMP: next_pc = j_target;
			core_pkg::BR_JUMP_REG: next_pc = rs_val;
			default: next_pc = pc_plus4;
		endcase
	end

	assign is_mem = ctrl.mem_read | ctrl.mem_write;
	assign dest = ctrl.link ? 5'd31 : (ctrl.regdst ? rd_idx : rt_idx);
	assign wb_data = ctrl.mem_read ? ls_rdata : alu_result;

	assign fetch_start = (state == ST_IDLE) && run;
	assign fetch_pc = pc;
	assign ls_start = (state == ST_EXEC) && !ctrl.ri && is_mem && !mem_done;
	// low address bits dropped, unaligned accesses hit the enclosing word
	assign ls_req.write = ctrl.mem_write;
	assign ls_req.addr = alu_result[core_pkg::addr_bits+1:2];
	assign ls_req.wdata = rt_val;

	assign retire = (state == ST_EXEC) && !ctrl.ri && (!is_mem || mem_done);
	assign trace.pc = pc;
	assign trace.we = ctrl.regwrite && (dest != 5'd0);
	assign trace.rd = dest;
	assign trace.value = wb_data;

	assign ri = (state == ST_EXEC) && ctrl.ri;
	assign ri_pc = pc;
	assign halted = (state == ST_HALT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pc <= core_pkg::reset_pc;
			mem_done <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (run)
						state <= ST_FETCH;
					else
						pc <= core_pkg::reset_pc;
				end
				ST_FETCH: begin
					if (fetch_done) begin
						mem_done <= 1'b0;
						state <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					if (ctrl.ri) begin
						state <= ST_HALT;
					end else if (is_mem && !mem_done) begin
						state <= ST_MEM;
					end else begin
						pc <= next_pc;
						state <= ST_IDLE;
					end
				end
				ST_MEM: begin
					// back to EXEC for the write-back pass
					if (ls_done) begin
						mem_done <= 1'b1;
						state <= ST_EXEC;
					end
				end
				default: state <= ST_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && fetch_done)
			ir <= fetch_instr;
		if (retire && ctrl.regwrite && dest != 5'd0)
			regs[dest] <= wb_data;
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [31:0] pc,
	output logic req,
	output core_pkg::mem_req_t req_data,
	input logic done,
	input core_pkg::mem_rsp_t rsp,
	output logic instr_done,
	output logic [31:0] instr
);

	logic busy;

	assign req = start && !busy;
	// byte pc to word address
	assign req_data.write = 1'b0;
	assign req_data.addr = pc[core_pkg::addr_bits+1:2];
	assign req_data.wdata = 32'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			instr_done <= 1'b0;
		end else begin
			instr_done <= done && busy;
			if (done)
				busy <= 1'b0;
			if (req)
				busy <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (done && busy)
			instr <= rsp.rdata;
	end

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
	input logic clk,
	input logic rst_n,
	input logic start,
	input core_pkg::mem_req_t ls_req,
	output logic req,
	output core_pkg::mem_req_t req_data,
	input logic done,
	input core_pkg::mem_rsp_t rsp,
	output logic ls_done,
	output logic [31:0] rdata
);

	logic busy;
	logic is_load;

	assign req = start && !busy;
	assign req_data = ls_req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			is_load <= 1'b0;
			ls_done <= 1'b0;
		end else begin
			ls_done <= done && busy;
			if (done)
				busy <= 1'b0;
			if (req) begin
				busy <= 1'b1;
				is_load <= !ls_req.write;
			end
		end
	end

	// stores leave the last loaded word in place
	always_ff @(posedge clk) begin
		if (done && busy && is_load)
			rdata <= rsp.rdata;
	end

endmodule

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
	input logic clk,
	input logic rst_n,
	input logic host_stb,
	input core_pkg::mem_req_t host_req,
	output logic host_done,
	input logic ls_stb,
	input core_pkg::mem_req_t ls_req,
	output logic ls_done,
	input logic fetch_stb,
	input core_pkg::mem_req_t fetch_req,
	output logic fetch_done,
	output logic ram_en,
	output core_pkg::mem_req_t ram_req,
	input core_pkg::mem_rsp_t ram_rsp,
	output core_pkg::mem_rsp_t rsp
);

	// slot 0 host, 1 load/store, 2 fetch
	logic [2:0] stb, pend, gnt, owner;
	core_pkg::mem_req_t in_req [3];
	core_pkg::mem_req_t slot [3];

	assign stb = {fetch_stb, ls_stb, host_stb};
	assign in_req[0] = host_req;
	assign in_req[1] = ls_req;
	assign in_req[2] = fetch_req;

	always_comb begin
		gnt = 3'b000;
		if (pend[0])
			gnt = 3'b001;
		else if (pend[1])
			gnt = 3'b010;
		else if (pend[2])
			gnt = 3'b100;
	end

	assign ram_en = |pend;

	always_comb begin
		ram_req = slot[2];
		if (gnt[0])
			ram_req = slot[0];
		else if (gnt[1])
			ram_req = slot[1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 3'b000;
			owner <= 3'b000;
		end else begin
			pend <= (pend & ~gnt) | stb;
			owner <= gnt;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (stb[i])
				slot[i] <= in_req[i];
		end
	end

	// read data lands the cycle after the grant
	assign {fetch_done, ls_done, host_done} = owner;
	assign rsp = ram_rsp;

endmodule

//--- rtl/unified_ram.sv
`timescale 1ns/1ns

module unified_ram (
	input logic clk,
	input logic en,
	input core_pkg::mem_req_t req,
	output core_pkg::mem_rsp_t rsp
);

	logic [31:0] mem [core_pkg::mem_words];

	// read returns the old word on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (req.write)
				mem[req.addr] <= req.wdata;
			rsp.rdata <= mem[req.addr];
		end
	end

endmodule

//--- rtl/mips_subsys.sv
`timescale 1ns/1ns

module mips_subsys (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic host_wr,
	input core_pkg::mem_req_t host_req,
	output logic host_done,
	output logic retire,
	output core_pkg::trace_t trace,
	output logic ri,
	output logic [31:0] ri_pc,
	output logic halted
);

	logic fetch_start, fetch_done, f_req, f_done;
	logic [31:0] fetch_pc, fetch_instr;
	logic ls_start, ls_done, l_req, l_done;
	logic [31:0] ls_rdata;
	logic ram_en;
	core_pkg::mem_req_t ls_req, f_req_data, l_req_data, ram_req;
	core_pkg::mem_rsp_t ram_rsp, arb_rsp;

	exec_core u_core (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.fetch_start(fetch_start),
		.fetch_pc(fetch_pc),
		.fetch_done(fetch_done),
		.fetch_instr(fetch_instr),
		.ls_start(ls_start),
		.ls_req(ls_req),
		.ls_done(ls_done),
		.ls_rdata(ls_rdata),
		.retire(retire),
		.trace(trace),
		.ri(ri),
		.ri_pc(ri_pc),
		.halted(halted)
	);

	fetch_unit u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.start(fetch_start),
		.pc(fetch_pc),
		.req(f_req),
		.req_data(f_req_data),
		.done(f_done),
		.rsp(arb_rsp),
		.instr_done(fetch_done),
		.instr(fetch_instr)
	);

	load_store_unit u_lsu (
		.clk(clk),
		.rst_n(rst_n),
		.start(ls_start),
		.ls_req(ls_req),
		.req(l_req),
		.req_data(l_req_data),
		.done(l_done),
		.rsp(arb_rsp),
		.ls_done(ls_done),
		.rdata(ls_rdata)
	);

	mem_arbiter u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.host_stb(host_wr),
		.host_req(host_req),
		.host_done(host_done),
		.ls_stb(l_req),
		.ls_req(l_req_data),
		.ls_done(l_done),
		.fetch_stb(f_req),
		.fetch_req(f_req_data),
		.fetch_done(f_done),
		.ram_en(ram_en),
		.ram_req(ram_req),
		.ram_rsp(ram_rsp),
		.rsp(arb_rsp)
	);

	unified_ram u_ram (
		.clk(clk),
		.en(ram_en),
		.req(ram_req),
		.rsp(ram_rsp)
	);

endmodule

//--- bench/tb_mips_subsys.sv
`timescale 1ns/1ns

module tb_mips_subsys;

	localparam int wait_limit = 200;

	logic clk;
	logic rst_n;
	logic run;
	logic host_wr;
	core_pkg::mem_req_t host_req;
	logic host_done;
	logic retire;
	core_pkg::trace_t trace;
	logic ri;
	logic [31:0] ri_pc;
	logic halted;

	// reference model state
	logic [31:0] mdl_mem [1024];
	logic [31:0] mdl_regs [32];
	logic [31:0] mdl_pc;
	logic [31:0] prog [$];
	logic [31:0] pc_log [$];

	// registers as reported by the trace
	logic [31:0] dut_regs [32];

	// host write racing with loads in test 5
	logic race_on;
	logic race_done;
	time race_done_time;
	logic [9:0] race_addr;
	logic [31:0] race_old;
	logic [31:0] race_new;

	int errors;
	int tests_run;
	int tests_failed;
	int unsigned seed;

	mips_subsys UUT (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.host_wr(host_wr),
		.host_req(host_req),
		.host_done(host_done),
		.retire(retire),
		.trace(trace),
		.ri(ri),
		.ri_pc(ri_pc),
		.halted(halted)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$finish;
	endtask

	task automatic apply_reset();
		run = 1'b0;
		host_wr = 1'b0;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	endtask

	task automatic host_write(input logic [9:0] addr, input logic [31:0] data);
		int n;
		@(posedge clk);
		#2;
		host_wr = 1'b1;
		host_req.write = 1'b1;
		host_req.addr = addr;
		host_req.wdata = data;
		@(posedge clk);
		#2 host_wr = 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!host_done && n < wait_limit);
		if (!host_done)
			abort_run("host write never completed");
		mdl_mem[addr] = data;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++)
			host_write(i[9:0], prog[i]);
	endtask

	// executes one instruction of the subset at mdl_pc
	task automatic model_step(output logic is_ri, output logic we, output logic [4:0] rd,
			output logic [31:0] val, output logic alt_ok, output logic [31:0] alt);
		logic [31:0] ins, a, b, imm_s, imm_z, nxt, addr;
		logic [5:0] op, fn;
		logic [4:0] rs, rt, sh;
		logic late;
		ins = mdl_mem[mdl_pc[11:2]];
		op = ins[31:26];
		fn = ins[5:0];
		rs = ins[25:21];
		rt = ins[20:16];
		sh = ins[10:6];
		a = (rs == 5'd0) ? 32'd0 : mdl_regs[rs];
		b = (rt == 5'd0) ? 32'd0 : mdl_regs[rt];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		imm_z = {16'd0, ins[15:0]};
		addr = a + imm_s;
		nxt = mdl_pc + 32'd4;
		is_ri = 1'b0;
		we = 1'b1;
		rd = rt;
		val = 32'd0;
		alt_ok = 1'b0;
		alt = 32'd0;
		case (op)
			isa_pkg::OP_R_TYPE: begin
				rd = ins[15:11];
				case (fn)
					isa_pkg::FN_ADDU: val = a + b;
					isa_pkg::FN_SUBU: val = a - b;
					isa_pkg::FN_AND: val = a & b;
					isa_pkg::FN_OR: val = a | b;
					isa_pkg::FN_XOR: val = a ^ b;
					isa_pkg::FN_NOR: val = ~(a | b);
					isa_pkg::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					isa_pkg::FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
					isa_pkg::FN_SLL: val = b << sh;
					isa_pkg::FN_SRL: val = b >> sh;
					isa_pkg::FN_SRA: val = $signed(b) >>> sh;
					isa_pkg::FN_JR: begin
						we = 1'b0;
						nxt = a;
					end
					default: is_ri = 1'b1;
				endcase
			end
			isa_pkg::OP_ADDIU: val = a + imm_s;
			isa_pkg::OP_SLTI: val = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
			isa_pkg::OP_SLTIU: val = (a < imm_s) ? 32'd1 : 32'd0;
			isa_pkg::OP_ANDI: val = a & imm_z;
			isa_pkg::OP_ORI: val = a | imm_z;
			isa_pkg::OP_XORI: val = a ^ imm_z;
			isa_pkg::OP_LUI: val = {ins[15:0], 16'd0};
			isa_pkg::OP_LW: begin
				val = mdl_mem[addr[11:2]];
				// loads close to the host write may see either word
				late = race_done && ($time > race_done_time + 20);
				if (race_on && addr[11:2] == race_addr && !late) begin
					val = race_old;
					alt = race_new;
					alt_ok = 1'b1;
				end else if (race_on && addr[11:2] == race_addr) begin
					val = race_new;
				end
			end
			isa_pkg::OP_SW: begin
				we = 1'b0;
				mdl_mem[addr[11:2]] = b;
			end
			isa_pkg::OP_BEQ: begin
				we = 1'b0;
				if (a == b)
					nxt = mdl_pc + 32'd4 + (imm_s << 2);
			end
			isa_pkg::OP_BNE: begin
				we = 1'b0;
				if (a != b)
					nxt = mdl_pc + 32'd4 + (imm_s << 2);
			end
			isa_pkg::OP_J: begin
				we = 1'b0;
				nxt = {nxt[31:28], ins[25:0], 2'b00};
			end
			isa_pkg::OP_JAL: begin
				rd = 5'd31;
				val = mdl_pc + 32'd4;
				nxt = {nxt[31:28], ins[25:0], 2'b00};
			end
			default: is_ri = 1'b1;
		endcase
		if (is_ri || rd == 5'd0)
			we = 1'b0;
		if (!is_ri)
			mdl_pc = nxt;
	endtask

	// runs from reset_pc until ri, checking every retirement
	task automatic run_and_check();
		logic m_ri, m_we, m_alt_ok;
		logic [4:0] m_rd;
		logic [31:0] m_val, m_alt, exp_pc, commit;
		logic stop;
		int n;
		mdl_pc = core_pkg::reset_pc;
		pc_log.delete();
		stop = 1'b0;
		@(posedge clk);
		#2 run = 1'b1;
		while (!stop) begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!retire && !ri && n < wait_limit);
			if (!retire && !ri)
				abort_run("core stopped retiring before the timeout");
			exp_pc = mdl_pc;
			model_step(m_ri, m_we, m_rd, m_val, m_alt_ok, m_alt);
			if (ri) begin
				check_eq("ri on a supported instruction", {31'd0, m_ri}, 32'd1);
				check_eq("ri pc", ri_pc, exp_pc);
				stop = 1'b1;
			end else begin
				check_eq("retire on a reserved instruction", {31'd0, m_ri}, 32'd0);
				check_eq("trace pc", trace.pc, exp_pc);
				check_eq("trace we", {31'd0, trace.we}, {31'd0, m_we});
				pc_log.push_back(trace.pc);
				if (trace.we)
					dut_regs[trace.rd] = trace.value;
				if (m_we) begin
					check_eq("trace rd", {27'd0, trace.rd}, {27'd0, m_rd});
					commit = (m_alt_ok && trace.value === m_alt) ? m_alt : m_val;
					check_eq("trace value", trace.value, commit);
					mdl_regs[m_rd] = commit;
				end
			end
		end
		@(negedge clk);
		check_eq("halted after ri", {31'd0, halted}, 32'd1);
	endtask

	task automatic report(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", name, errors - err_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic test_alu_ops();
		int e;
		logic [31:0] v1, v2;
		logic [15:0] imm;
		logic [4:0] sh;
		e = errors;
		v1 = $urandom;
		v2 = $urandom;
		imm = 16'($urandom);
		sh = 5'($urandom);
		apply_reset();
		prog = {enc_i(isa_pkg::OP_LUI, 0, 1, v1[31:16]), enc_i(isa_pkg::OP_ORI, 1, 1, v1[15:0]),
			enc_i(isa_pkg::OP_LUI, 0, 2, v2[31:16]), enc_i(isa_pkg::OP_ORI, 2, 2, v2[15:0]),
			enc_r(isa_pkg::FN_ADDU, 1, 2, 3, 0), enc_r(isa_pkg::FN_SUBU, 1, 2, 4, 0),
			enc_r(isa_pkg::FN_AND, 1, 2, 5, 0), enc_r(isa_pkg::FN_OR, 1, 2, 6, 0),
			enc_r(isa_pkg::FN_XOR, 1, 2, 7, 0), enc_r(isa_pkg::FN_NOR, 1, 2, 8, 0),
			enc_r(isa_pkg::FN_SLT, 1, 2, 9, 0), enc_r(isa_pkg::FN_SLTU, 1, 2, 10, 0),
			enc_r(isa_pkg::FN_SLL, 0, 2, 11, sh), enc_r(isa_pkg::FN_SRL, 0, 1, 12, sh),
			enc_r(isa_pkg::FN_SRA, 0, 1, 13, sh), enc_i(isa_pkg::OP_ADDIU, 1, 14, imm),
			enc_i(isa_pkg::OP_SLTI, 2, 15, imm), enc_i(isa_pkg::OP_SLTIU, 1, 16, imm),
			enc_i(isa_pkg::OP_ANDI, 1, 17, imm), enc_i(isa_pkg::OP_ORI, 2, 18, imm),
			enc_i(isa_pkg::OP_XORI, 1, 19, imm), enc_r(isa_pkg::FN_ADDU, 1, 2, 0, 0),
			enc_r(isa_pkg::FN_OR, 0, 0, 20, 0), 32'hffff_ffff};
		load_program();
		run_and_check();
		check_eq("r20 from r0", dut_regs[20], 32'd0);
		report("test 1 register and immediate ops", e);
	endtask

	task automatic test_store_load();
		int e;
		logic [31:0] v;
		e = errors;
		v = $urandom;
		apply_reset();
		prog = {enc_i(isa_pkg::OP_ADDIU, 0, 1, 16'h0200), enc_i(isa_pkg::OP_LUI, 0, 2, v[31:16]),
			enc_i(isa_pkg::OP_ORI, 2, 2, v[15:0]), enc_i(isa_pkg::OP_SW, 1, 2, 16'h0004),
			enc_i(isa_pkg::OP_LW, 1, 3, 16'h0004), 32'hffff_ffff};
		load_program();
		run_and_check();
		check_eq("loaded word", dut_regs[3], v);
		report("test 2 store then load", e);
	endtask

	task automatic test_control_flow();
		int e;
		logic [31:0] exp_pcs [$];
		e = errors;
		apply_reset();
		prog = {enc_i(isa_pkg::OP_ADDIU, 0, 1, 5), enc_i(isa_pkg::OP_ADDIU, 0, 2, 5),
			enc_i(isa_pkg::OP_BEQ, 1, 2, 1), enc_i(isa_pkg::OP_ADDIU, 0, 3, 1),
			enc_i(isa_pkg::OP_BNE, 1, 2, 1), enc_i(isa_pkg::OP_BEQ, 1, 0, 1),
			enc_i(isa_pkg::OP_BNE, 1, 0, 1), enc_i(isa_pkg::OP_ADDIU, 0, 3, 2),
			enc_j(isa_pkg::OP_J, 10), enc_i(isa_pkg::OP_ADDIU, 0, 5, 3),
			enc_j(isa_pkg::OP_JAL, 14), enc_i(isa_pkg::OP_ADDIU, 0, 7, 9),
			32'hffff_ffff, enc_i(isa_pkg::OP_ADDIU, 0, 8, 4),
			enc_i(isa_pkg::OP_ADDIU, 0, 6, 7), enc_r(isa_pkg::FN_JR, 31, 0, 0, 0)};
		exp_pcs = {0, 4, 8, 16, 20, 24, 32, 40, 56, 60, 44};
		load_program();
		run_and_check();
		check_eq("retire count", pc_log.size(), exp_pcs.size());
		for (int i = 0; i < exp_pcs.size() && i < pc_log.size(); i++)
			check_eq("pc sequence", pc_log[i], exp_pcs[i]);
		check_eq("link register", dut_regs[31], 32'd44);
		report("test 3 control flow", e);
	endtask

	task automatic test_reserved();
		int e;
		logic late_retire;
		e = errors;
		late_retire = 1'b0;
		apply_reset();
		prog = {enc_i(isa_pkg::OP_ADDIU, 0, 1, 1), enc_i(isa_pkg::OP_REGIMM, 1, 0, 0),
			enc_i(isa_pkg::OP_ADDIU, 0, 2, 2)};
		load_program();
		run_and_check();
		check_eq("ri pc", ri_pc, 32'd4);
		repeat (40) begin
			@(negedge clk);
			if (retire)
				late_retire = 1'b1;
		end
		check_eq("retire after halt", {31'd0, late_retire}, 32'd0);
		check_eq("still halted", {31'd0, halted}, 32'd1);
		report("test 4 reserved instruction", e);
	endtask

	task automatic test_arbitration();
		int e;
		e = errors;
		apply_reset();
		race_addr = 10'd64;
		race_old = $urandom;
		race_new = ~race_old;
		host_write(race_addr, race_old);
		prog = {enc_i(isa_pkg::OP_ADDIU, 0, 1, 8), enc_i(isa_pkg::OP_LW, 0, 2, 16'h0100),
			enc_i(isa_pkg::OP_ADDIU, 1, 1, 16'hffff), enc_i(isa_pkg::OP_BNE, 1, 0, 16'hfffd),
			32'hffff_ffff};
		load_program();
		race_on = 1'b1;
		race_done = 1'b0;
		fork
			begin
				repeat (30) @(posedge clk);
				host_write(race_addr, race_new);
				race_done_time = $time;
				race_done = 1'b1;
			end
			run_and_check();
		join
		check_eq("last load", dut_regs[2], race_new);
		race_on = 1'b0;
		report("test 5 host write during loads", e);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		host_wr = 1'b0;
		host_req = '0;
		race_on = 1'b0;
		race_done = 1'b0;
		race_done_time = 0;
		race_addr = '0;
		race_old = '0;
		race_new = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		seed = $urandom(32'hb07e);
		for (int i = 0; i < 1024; i++)
			mdl_mem[i] = 32'd0;
		for (int i = 0; i < 32; i++) begin
			mdl_regs[i] = 32'd0;
			dut_regs[i] = 32'd0;
		end
		test_alu_ops();
		test_store_load();
		test_control_flow();
		test_reserved();
		test_arbitration();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- build.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/main_decoder.sv
rtl/alu.sv
rtl/exec_core.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/mem_arbiter.sv
rtl/unified_ram.sv
rtl/mips_subsys.sv
bench/tb_mips_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mips_subsys
FLIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
